// File: uart_pkg.sv
// 8N1 UART shared definitions; bit periods are in clock cycles and must stay at or above BIT_PERIOD_MIN
`default_nettype none

package uart_pkg;

  // width of every bit-period count and register
  localparam int BIT_PERIOD_W = 16;

  // small reset value so simulation frames stay short
  localparam logic [BIT_PERIOD_W-1:0] BIT_PERIOD_RESET = 16'd16;

  // below this the receiver cannot find a usable mid-bit sample point
  localparam logic [BIT_PERIOD_W-1:0] BIT_PERIOD_MIN = 16'd4;

  // transmit queue entries, also the credits the host holds after reset
  localparam int TX_QUEUE_DEPTH = 8;

  // host to queue and queue to transmitter payload
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } uart_byte_t;

  // one received frame, valid for a single cycle
  typedef struct packed {
    logic       valid;
    logic       frame_err;
    logic [7:0] data;
  } uart_rx_byte_t;

  // bit-period register write
  typedef struct packed {
    logic                    wr_en;
    logic [BIT_PERIOD_W-1:0] bit_period;
  } uart_cfg_wr_t;

  typedef enum logic [2:0] {
    TX_IDLE    = 3'd0,
    TX_START   = 3'd1,
    TX_DATA    = 3'd2,
    TX_STOP    = 3'd3,
    TX_CLEANUP = 3'd4
  } uart_tx_state_t;

endpackage

`default_nettype wire

// File: uart_cfg.sv
// bit-period register; write it only while the transmitter is idle and the line is quiet
`default_nettype none

module uart_cfg (
  input  wire logic                              i_Clock,
  input  wire logic                              i_arst_n,
  input  wire uart_pkg::uart_cfg_wr_t            i_cfg_wr,
  output logic [uart_pkg::BIT_PERIOD_W-1:0]      o_bit_period
);

  import uart_pkg::*;

  logic [BIT_PERIOD_W-1:0] r_bit_period;
  logic [BIT_PERIOD_W-1:0] wr_value;

  // too short a period is raised to the minimum instead of being rejected
  always_comb
  begin
    if (i_cfg_wr.bit_period < BIT_PERIOD_MIN)
    begin
      wr_value = BIT_PERIOD_MIN;
    end
    else
    begin
      wr_value = i_cfg_wr.bit_period;
    end
  end

  always_ff @(posedge i_Clock or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      r_bit_period <= BIT_PERIOD_RESET;
    end
    else if (i_cfg_wr.wr_en)
    begin
      r_bit_period <= wr_value;
    end
  end

  // both serial engines read this directly
  assign o_bit_period = r_bit_period;

  // the receiver half-bit check relies on this floor
  a_period_min: assert property (
    @(posedge i_Clock) disable iff (!i_arst_n)
    r_bit_period >= BIT_PERIOD_MIN
  ) else $error("bit period below minimum: %0d", r_bit_period);

endmodule

`default_nettype wire

// File: uart_tx_queue.sv
// credit-based transmit queue; it never refuses a byte, so the host must hold a credit per write
`default_nettype none

module uart_tx_queue #(
  parameter int DEPTH = 8
) (
  input  wire logic                  i_Clock,
  input  wire logic                  i_arst_n,
  input  wire uart_pkg::uart_byte_t  i_tx_byte,
  input  wire logic                  i_tx_ready,
  output uart_pkg::uart_byte_t       o_tx_head,
  output logic                       o_tx_credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [7:0]       mem [DEPTH];
  logic [PTR_W-1:0] r_wr_ptr;
  logic [PTR_W-1:0] r_rd_ptr;
  logic [CNT_W-1:0] r_count;
  logic             push;
  logic             pop;

  assign push = i_tx_byte.valid;
  // a byte leaves whenever the head is valid and the transmitter is idle
  assign pop  = o_tx_head.valid && i_tx_ready;

  always_ff @(posedge i_Clock)
  begin
    if (push)
    begin
      mem[r_wr_ptr] <= i_tx_byte.data;
    end
  end

  always_ff @(posedge i_Clock or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end
    else
    begin
      if (push)
      begin
        r_wr_ptr <= (r_wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
      end
      if (pop)
      begin
        r_rd_ptr <= (r_rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  assign o_tx_head.valid = (r_count != '0);
  assign o_tx_head.data  = mem[r_rd_ptr];

  // one credit back per popped byte, same cycle as the pop
  assign o_tx_credit = pop;

  a_no_write_full: assert property (
    @(posedge i_Clock) disable iff (!i_arst_n)
    i_tx_byte.valid |-> (r_count != CNT_W'(DEPTH))
  ) else $error("host credit violation: write while queue full");

  a_count_bound: assert property (
    @(posedge i_Clock) disable iff (!i_arst_n)
    r_count <= CNT_W'(DEPTH)
  ) else $error("queue occupancy %0d above depth", r_count);

endmodule

`default_nettype wire

// File: uart_tx.sv
// 8N1 serial transmitter; the bit period is sampled live, so change it only while idle
`default_nettype none

module uart_tx (
  input  wire logic                          i_Clock,
  input  wire logic                          i_arst_n,
  input  wire logic [uart_pkg::BIT_PERIOD_W-1:0] i_bit_period,
  input  wire uart_pkg::uart_byte_t          i_tx_head,
  output logic                               o_tx_ready,
  output logic                               o_tx_serial,
  output logic                               o_tx_busy
);

  import uart_pkg::*;

  uart_tx_state_t          r_state;
  logic [BIT_PERIOD_W-1:0] r_clk_count;
  logic [2:0]              r_bit_idx;
  logic [7:0]              r_tx_data;
  logic                    bit_done;

  assign bit_done = (r_clk_count >= i_bit_period - 1'b1);

  // the line level is registered, so it trails the state by one cycle
  always_ff @(posedge i_Clock or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      r_state     <= TX_IDLE;
      r_clk_count <= '0;
      r_bit_idx   <= '0;
      o_tx_serial <= 1'b1;
    end
    else
    begin
      case (r_state)
        TX_IDLE:
        begin
          o_tx_serial <= 1'b1;
          r_clk_count <= '0;
          r_bit_idx   <= '0;
          if (i_tx_head.valid)
          begin
            r_state <= TX_START;
          end
        end
        TX_START:
        begin
          o_tx_serial <= 1'b0;
          r_clk_count <= bit_done ? '0 : r_clk_count + 1'b1;
          if (bit_done)
          begin
            r_state <= TX_DATA;
          end
        end
        TX_DATA:
        begin
          // lsb first
          o_tx_serial <= r_tx_data[r_bit_idx];
          r_clk_count <= bit_done ? '0 : r_clk_count + 1'b1;
          if (bit_done)
          begin
            r_bit_idx <= r_bit_idx + 3'd1;
            if (r_bit_idx == 3'd7)
            begin
              r_state <= TX_STOP;
            end
          end
        end
        TX_STOP:
        begin
          o_tx_serial <= 1'b1;
          r_clk_count <= bit_done ? '0 : r_clk_count + 1'b1;
          if (bit_done)
          begin
            r_state <= TX_CLEANUP;
          end
        end
        TX_CLEANUP:
        begin
          // one extra high cycle between frames
          o_tx_serial <= 1'b1;
          r_state     <= TX_IDLE;
        end
        default: r_state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_Clock)
  begin
    if (r_state == TX_IDLE && i_tx_head.valid)
    begin
      r_tx_data <= i_tx_head.data;
    end
  end

  assign o_tx_ready = (r_state == TX_IDLE);
  assign o_tx_busy  = (r_state != TX_IDLE);

  a_idle_line_high: assert property (
    @(posedge i_Clock) disable iff (!i_arst_n)
    (r_state == TX_IDLE) |-> o_tx_serial
  ) else $error("serial line low while transmitter idle");

endmodule

`default_nettype wire

// File: uart_rx.sv
// 8N1 receiver with no back-pressure; each byte is valid for one cycle, bit period must be at least 4
`default_nettype none

module uart_rx (
  input  wire logic                              i_Clock,
  input  wire logic                              i_arst_n,
  input  wire logic [uart_pkg::BIT_PERIOD_W-1:0] i_bit_period,
  input  wire logic                              i_rx_serial,
  output uart_pkg::uart_rx_byte_t                o_rx_byte
);

  import uart_pkg::*;

  typedef enum logic [2:0] {
    RX_WAIT  = 3'd0,
    RX_IDLE  = 3'd1,
    RX_START = 3'd2,
    RX_DATA  = 3'd3,
    RX_STOP  = 3'd4
  } rx_state_t;

  rx_state_t               r_state;
  logic [1:0]              r_sync;
  logic [BIT_PERIOD_W-1:0] r_clk_count;
  logic [BIT_PERIOD_W-1:0] half_period;
  logic [2:0]              r_bit_idx;
  logic [7:0]              r_shift;
  logic                    r_valid;
  logic                    r_frame_err;
  logic                    rx_in;
  logic                    bit_done;

  assign rx_in       = r_sync[1];
  assign half_period = {1'b0, i_bit_period[BIT_PERIOD_W-1:1]};
  assign bit_done    = (r_clk_count >= i_bit_period - 1'b1);

  // two flops against metastability on the asynchronous line
  always_ff @(posedge i_Clock or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      r_sync <= 2'b11;
    end
    else
    begin
      r_sync <= {r_sync[0], i_rx_serial};
    end
  end

  // RX_WAIT holds off until the line is high, so RX_IDLE only sees real falling edges
  always_ff @(posedge i_Clock or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      r_state     <= RX_WAIT;
      r_clk_count <= '0;
      r_bit_idx   <= '0;
      r_valid     <= 1'b0;
    end
    else
    begin
      r_valid <= 1'b0;
      case (r_state)
        RX_WAIT:
        begin
          if (rx_in)
          begin
            r_state <= RX_IDLE;
          end
        end
        RX_IDLE:
        begin
          r_clk_count <= '0;
          r_bit_idx   <= '0;
          if (!rx_in)
          begin
            r_state <= RX_START;
          end
        end
        RX_START:
        begin
          r_clk_count <= r_clk_count + 1'b1;
          if (r_clk_count >= half_period - 1'b1)
          begin
            // glitch if the line is already back high at mid start bit
            r_clk_count <= '0;
            r_state     <= rx_in ? RX_WAIT : RX_DATA;
          end
        end
        RX_DATA:
        begin
          r_clk_count <= bit_done ? '0 : r_clk_count + 1'b1;
          if (bit_done)
          begin
            r_bit_idx <= r_bit_idx + 3'd1;
            if (r_bit_idx == 3'd7)
            begin
              r_state <= RX_STOP;
            end
          end
        end
        RX_STOP:
        begin
          r_clk_count <= bit_done ? '0 : r_clk_count + 1'b1;
          if (bit_done)
          begin
            r_valid <= 1'b1;
            r_state <= RX_WAIT;
          end
        end
        default: r_state <= RX_WAIT;
      endcase
    end
  end

  always_ff @(posedge i_Clock)
  begin
    if (r_state == RX_DATA && bit_done)
    begin
      r_shift <= {rx_in, r_shift[7:1]};
    end
    if (r_state == RX_STOP && bit_done)
    begin
      r_frame_err <= !rx_in;
    end
  end

  assign o_rx_byte.valid     = r_valid;
  assign o_rx_byte.frame_err = r_frame_err;
  assign o_rx_byte.data      = r_shift;

  a_valid_pulse: assert property (
    @(posedge i_Clock) disable iff (!i_arst_n)
    o_rx_byte.valid |=> !o_rx_byte.valid
  ) else $error("rx valid held for more than one cycle");

endmodule

`default_nettype wire

// File: uart_top.sv
// UART peripheral top; the receiver input is external so it can be looped back or driven apart
`default_nettype none

module uart_top (
  input  wire logic                    i_Clock,
  input  wire logic                    i_arst_n,
  input  wire uart_pkg::uart_cfg_wr_t  i_cfg_wr,
  input  wire uart_pkg::uart_byte_t    i_tx_byte,
  output logic                         o_tx_credit,
  output logic                         o_tx_serial,
  output logic                         o_tx_busy,
  input  wire logic                    i_rx_serial,
  output uart_pkg::uart_rx_byte_t      o_rx_byte
);

  import uart_pkg::*;

  logic [BIT_PERIOD_W-1:0] bit_period;
  uart_byte_t              tx_head;
  logic                    tx_ready;

  uart_cfg u_cfg (
    .i_Clock      (i_Clock),
    .i_arst_n     (i_arst_n),
    .i_cfg_wr     (i_cfg_wr),
    .o_bit_period (bit_period)
  );

  uart_tx_queue #(
    .DEPTH (TX_QUEUE_DEPTH)
  ) u_tx_queue (
    .i_Clock     (i_Clock),
    .i_arst_n    (i_arst_n),
    .i_tx_byte   (i_tx_byte),
    .i_tx_ready  (tx_ready),
    .o_tx_head   (tx_head),
    .o_tx_credit (o_tx_credit)
  );

  uart_tx u_tx (
    .i_Clock      (i_Clock),
    .i_arst_n     (i_arst_n),
    .i_bit_period (bit_period),
    .i_tx_head    (tx_head),
    .o_tx_ready   (tx_ready),
    .o_tx_serial  (o_tx_serial),
    .o_tx_busy    (o_tx_busy)
  );

  uart_rx u_rx (
    .i_Clock      (i_Clock),
    .i_arst_n     (i_arst_n),
    .i_bit_period (bit_period),
    .i_rx_serial  (i_rx_serial),
    .o_rx_byte    (o_rx_byte)
  );

endmodule

`default_nettype wire

// File: tb_uart_top.sv
// self-checking testbench for uart_top; needs timing support, keeps bit periods at 32 cycles or less
`default_nettype none

module tb_uart_top;

  timeunit 1ns;
  timeprecision 1ps;

  import uart_pkg::*;

  localparam int SEED       = 68160;
  localparam int WAIT_LIMIT = 20000;

  logic          i_Clock;
  logic          i_arst_n;
  uart_cfg_wr_t  i_cfg_wr;
  uart_byte_t    i_tx_byte;
  logic          o_tx_credit;
  logic          o_tx_serial;
  logic          o_tx_busy;
  logic          rx_line;
  uart_rx_byte_t o_rx_byte;
  logic          inject;
  logic          inject_line;

  // reference stream of expected frames as {frame_err, data}
  logic [8:0] expect_q [$];
  int         credits;
  int         cur_period;
  int         errors;
  int         rx_seen;
  int         tests_run;
  int         tests_failed;

  // serial line switch, loopback unless a frame is being injected
  assign rx_line = inject ? inject_line : o_tx_serial;

  uart_top u_uart_top (
    .i_Clock     (i_Clock),
    .i_arst_n    (i_arst_n),
    .i_cfg_wr    (i_cfg_wr),
    .i_tx_byte   (i_tx_byte),
    .o_tx_credit (o_tx_credit),
    .o_tx_serial (o_tx_serial),
    .o_tx_busy   (o_tx_busy),
    .i_rx_serial (rx_line),
    .o_rx_byte   (o_rx_byte)
  );

  initial
  begin
    i_Clock = 1'b0;
    forever #20 i_Clock = ~i_Clock;
  end

  function automatic void report_error(input string msg);
    errors++;
    $display("[ERROR] %0t ns: %s", $time, msg);
  endfunction

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Result: FAILED");
    $finish;
  endtask

  // mid-cycle monitor: credits and received bytes are stable at the falling edge
  always @(negedge i_Clock)
  begin
    logic [8:0] exp_entry;
    if (i_arst_n)
    begin
      credits = credits + (o_tx_credit ? 1 : 0) - (i_tx_byte.valid ? 1 : 0);
      assert (credits >= 0 && credits <= TX_QUEUE_DEPTH)
        else report_error($sformatf("credit count %0d out of range", credits));
      if (o_rx_byte.valid)
      begin
        rx_seen++;
        assert (expect_q.size() != 0)
          else report_error($sformatf("unexpected received byte %02h", o_rx_byte.data));
        if (expect_q.size() != 0)
        begin
          exp_entry = expect_q.pop_front();
          assert (o_rx_byte.data == exp_entry[7:0] && o_rx_byte.frame_err == exp_entry[8])
            else report_error($sformatf("received %02h err %0b, expected %02h err %0b",
                                        o_rx_byte.data, o_rx_byte.frame_err,
                                        exp_entry[7:0], exp_entry[8]));
        end
      end
    end
  end

  // drives one byte on the next edge that has a credit behind it
  task automatic send_byte(input logic [7:0] data);
    int n;
    n = 0;
    @(posedge i_Clock);
    while (credits == 0 && n < WAIT_LIMIT)
    begin
      i_tx_byte <= '0;
      @(posedge i_Clock);
      n++;
    end
    if (credits == 0)
      stop_on_timeout("a transmit credit");
    i_tx_byte <= {1'b1, data};
    expect_q.push_back({1'b0, data});
  endtask

  task automatic host_idle();
    @(posedge i_Clock);
    i_tx_byte <= '0;
  endtask

  task automatic write_period(input int val);
    @(posedge i_Clock);
    i_cfg_wr <= {1'b1, BIT_PERIOD_W'(val)};
    @(posedge i_Clock);
    i_cfg_wr <= '0;
    cur_period = (val < int'(BIT_PERIOD_MIN)) ? int'(BIT_PERIOD_MIN) : val;
  endtask

  // all expected bytes received and the transmitter back to a quiet line
  task automatic wait_drain(input string what);
    int n;
    n = 0;
    @(negedge i_Clock);
    while ((expect_q.size() != 0 || o_tx_busy || !o_tx_serial) && n < WAIT_LIMIT)
    begin
      @(negedge i_Clock);
      n++;
    end
    if (n >= WAIT_LIMIT)
      stop_on_timeout(what);
  endtask

  // k counts falling edges from the first low sample of the start bit
  task automatic check_frame(input logic [7:0] data, input int period);
    logic [8:0] frame_bits;
    int         n;
    int         k;
    int         width;
    frame_bits = {1'b1, data};
    n = 0;
    @(negedge i_Clock);
    while (o_tx_serial && n < WAIT_LIMIT)
    begin
      @(negedge i_Clock);
      n++;
    end
    if (n >= WAIT_LIMIT)
      stop_on_timeout("a start bit on the serial output");
    width = 0;
    while (!o_tx_serial && width < 4 * period)
    begin
      @(negedge i_Clock);
      width++;
    end
    assert (width == period)
      else report_error($sformatf("start bit %0d cycles, expected %0d", width, period));
    k = width;
    for (int i = 0; i < 9; i++)
    begin
      while (k < period * (1 + i) + period / 2)
      begin
        @(negedge i_Clock);
        k++;
      end
      assert (o_tx_serial == frame_bits[i])
        else report_error($sformatf("frame bit %0d is %0b at mid-bit", i, o_tx_serial));
    end
  endtask

  task automatic inject_frame(input logic [7:0] data, input logic stop_bit);
    logic [9:0] levels;
    levels = {stop_bit, data, 1'b0};
    expect_q.push_back({~stop_bit, data});
    @(posedge i_Clock);
    inject      <= 1'b1;
    inject_line <= 1'b1;
    repeat (2) @(posedge i_Clock);
    for (int i = 0; i < 10; i++)
    begin
      inject_line <= levels[i];
      repeat (cur_period) @(posedge i_Clock);
    end
    inject_line <= 1'b1;
  endtask

  task automatic finish_test(input string name, input int base_err);
    tests_run++;
    if (errors == base_err)
      $display("test %0d %s: ok", tests_run, name);
    else
    begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - base_err);
    end
  endtask

  initial
  begin
    int         base_err;
    int         base_rx;
    int         val;
    logic [7:0] d;
    i_arst_n     = 1'b0;
    i_cfg_wr     = '0;
    i_tx_byte    = '0;
    inject       = 1'b0;
    inject_line  = 1'b1;
    credits      = TX_QUEUE_DEPTH;
    cur_period   = int'(BIT_PERIOD_RESET);
    errors       = 0;
    rx_seen      = 0;
    tests_run    = 0;
    tests_failed = 0;
    void'($urandom(SEED));
    repeat (4) @(posedge i_Clock);
    i_arst_n <= 1'b1;

    base_err = errors;
    repeat (8)
    begin
      @(negedge i_Clock);
      assert (o_tx_serial && !o_tx_busy && !o_tx_credit && !o_rx_byte.valid)
        else report_error("outputs not at their reset values");
    end
    finish_test("reset state", base_err);

    base_err = errors;
    base_rx  = rx_seen;
    repeat (40)
    begin
      send_byte(8'($urandom));
      repeat ($urandom_range(2, 0)) host_idle();
    end
    host_idle();
    wait_drain("random loopback bytes");
    assert (rx_seen - base_rx == 40)
      else report_error($sformatf("received %0d bytes, expected 40", rx_seen - base_rx));
    finish_test("random loopback", base_err);

    base_err = errors;
    base_rx  = rx_seen;
    assert (credits == TX_QUEUE_DEPTH)
      else report_error($sformatf("%0d credits before burst", credits));
    repeat (TX_QUEUE_DEPTH) send_byte(8'($urandom));
    host_idle();
    wait_drain("the burst");
    assert (rx_seen - base_rx == TX_QUEUE_DEPTH)
      else report_error($sformatf("received %0d burst bytes, expected %0d",
                                  rx_seen - base_rx, TX_QUEUE_DEPTH));
    repeat (2) @(posedge i_Clock);
    assert (credits == TX_QUEUE_DEPTH)
      else report_error($sformatf("%0d credits after burst", credits));
    finish_test("credit flow", base_err);

    // odd bytes keep data bit 0 high so the start bit low time stands alone
    base_err = errors;
    d = 8'($urandom) | 8'h01;
    send_byte(d);
    host_idle();
    check_frame(d, cur_period);
    wait_drain("the timed frame");
    finish_test("bit timing", base_err);

    base_err = errors;
    val = int'($urandom_range(32, int'(BIT_PERIOD_MIN)));
    write_period(val);
    d = 8'($urandom) | 8'h01;
    send_byte(d);
    host_idle();
    check_frame(d, cur_period);
    repeat (10) send_byte(8'($urandom));
    host_idle();
    wait_drain("bytes at the new bit period");
    val = int'($urandom_range(int'(BIT_PERIOD_MIN) - 1, 0));
    write_period(val);
    d = 8'($urandom) | 8'h01;
    send_byte(d);
    host_idle();
    check_frame(d, int'(BIT_PERIOD_MIN));
    wait_drain("the frame at the clamped period");
    finish_test("configuration", base_err);

    base_err = errors;
    base_rx  = rx_seen;
    write_period(int'(BIT_PERIOD_RESET));
    inject_frame(8'($urandom), 1'b0);
    wait_drain("the frame with a low stop bit");
    inject_frame(8'($urandom), 1'b1);
    wait_drain("the good injected frame");
    @(posedge i_Clock);
    inject <= 1'b0;
    assert (rx_seen - base_rx == 2)
      else report_error($sformatf("received %0d injected frames, expected 2", rx_seen - base_rx));
    finish_test("framing error", base_err);

    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
uart_pkg.sv
uart_cfg.sv
uart_tx_queue.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
tb_uart_top.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/1ps \
  --top-module tb_uart_top \
  -f all.f \
  -o sim_uart

./obj_dir/sim_uart > sim.log 2>&1 || true
cat sim.log

if grep -qx "Result: PASSED" sim.log; then
  echo "simulation run passed"
else
  echo "simulation run failed"
  exit 1
fi
